// File: cpu_types_pkg.sv
package cpu_types_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  // HALT encodes as all ones
  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    J     = 6'b000010,
    BEQ   = 6'b000100,
    BNE   = 6'b000101,
    ADDIU = 6'b001001,
    ORI   = 6'b001101,
    LUI   = 6'b001111,
    LW    = 6'b100011,
    SW    = 6'b101011,
    HALT  = 6'b111111
  } opcode_t;

  typedef enum logic [5:0] {
    SLL  = 6'b000000,
    ADDU = 6'b100001,
    SUBU = 6'b100011,
    AND  = 6'b100100,
    OR   = 6'b100101,
    SLT  = 6'b101010
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL, ALU_LUI
  } aluop_t;

  typedef enum logic [1:0] {ALUB_RDAT, ALUB_EXT, ALUB_SHAMT} alub_sel_t;
  typedef enum logic       {RFIN_ALU, RFIN_RAM} rfin_sel_t;
  typedef enum logic [1:0] {PC_NPC, PC_BR, PC_JMP} pc_sel_t;
  typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_t;

  // All zeros is a bubble
  typedef struct packed {
    aluop_t    aluop;
    alub_sel_t alub_sel;
    rfin_sel_t rfin_sel;
    logic      rf_wen;
    logic      dren;
    logic      dwen;
    logic      halt;
    regbits_t  wsel;
  } ctrl_t;

  typedef struct packed {
    word_t instr;
    word_t npc;
  } if_id_t;

  typedef struct packed {
    ctrl_t    ctrl;
    regbits_t rs;
    regbits_t rt;
    word_t    rdat1;
    word_t    rdat2;
    word_t    ext32;
    word_t    shamt;
  } id_ex_t;

  typedef struct packed {
    ctrl_t ctrl;
    word_t aluout;
    word_t dmemstore;
  } ex_mem_t;

  typedef struct packed {
    ctrl_t ctrl;
    word_t aluout;
    word_t dmemload;
  } mem_wb_t;

endpackage

// File: alu.sv
module alu (
  input  cpu_types_pkg::word_t  a_i,
  input  cpu_types_pkg::word_t  b_i,
  input  cpu_types_pkg::aluop_t op_i,
  output cpu_types_pkg::word_t  out_o
);
  import cpu_types_pkg::*;

  always_comb begin
    case (op_i)
      ALU_ADD: out_o = a_i + b_i;
      ALU_SUB: out_o = a_i - b_i;
      ALU_AND: out_o = a_i & b_i;
      ALU_OR:  out_o = a_i | b_i;
      // Signed compare
      ALU_SLT: out_o = {31'b0, $signed(a_i) < $signed(b_i)};
      ALU_SLL: out_o = a_i << b_i[4:0];
      ALU_LUI: out_o = {b_i[15:0], 16'h0000};
      default: out_o = '0;
    endcase
  end

endmodule

// File: decode_unit.sv
module decode_unit (
  input  cpu_types_pkg::word_t    instr_i,
  input  logic                    equal_i,
  output cpu_types_pkg::ctrl_t    ctrl_o,
  output cpu_types_pkg::regbits_t rsel1_o,
  output cpu_types_pkg::regbits_t rsel2_o,
  output cpu_types_pkg::word_t    ext32_o,
  output cpu_types_pkg::word_t    shamt_o,
  output logic                    is_branch_o,
  output cpu_types_pkg::pc_sel_t  pc_sel_o,
  output cpu_types_pkg::word_t    jtarget_o
);
  import cpu_types_pkg::*;

  opcode_t  opcode;
  funct_t   funct;
  regbits_t rs;
  regbits_t rt;
  regbits_t rd;

  assign opcode = opcode_t'(instr_i[31:26]);
  assign funct  = funct_t'(instr_i[5:0]);
  assign rs     = instr_i[25:21];
  assign rt     = instr_i[20:16];
  assign rd     = instr_i[15:11];

  // SLL shifts rt, which goes through the A side of the ALU
  assign rsel1_o = (opcode == RTYPE && funct == SLL) ? rt : rs;
  assign rsel2_o = rt;

  assign ext32_o = (opcode == ORI) ? {16'h0000, instr_i[15:0]}
                                   : {{16{instr_i[15]}}, instr_i[15:0]};
  assign shamt_o = {27'h0, instr_i[10:6]};
  // Upper four bits come from npc in the datapath
  assign jtarget_o   = {4'h0, instr_i[25:0], 2'b00};
  assign is_branch_o = (opcode == BEQ) || (opcode == BNE);

  always_comb begin
    ctrl_o   = '0;
    pc_sel_o = PC_NPC;
    case (opcode)
      RTYPE: begin
        ctrl_o.rf_wen = 1'b1;
        ctrl_o.wsel   = rd;
        case (funct)
          ADDU: ctrl_o.aluop = ALU_ADD;
          SUBU: ctrl_o.aluop = ALU_SUB;
          AND:  ctrl_o.aluop = ALU_AND;
          OR:   ctrl_o.aluop = ALU_OR;
          SLT:  ctrl_o.aluop = ALU_SLT;
          SLL: begin
            ctrl_o.aluop    = ALU_SLL;
            ctrl_o.alub_sel = ALUB_SHAMT;
          end
          default: ctrl_o = '0;
        endcase
      end
      ADDIU, ORI, LUI, LW: begin
        ctrl_o.rf_wen   = 1'b1;
        ctrl_o.wsel     = rt;
        ctrl_o.alub_sel = ALUB_EXT;
        case (opcode)
          ORI:     ctrl_o.aluop = ALU_OR;
          LUI:     ctrl_o.aluop = ALU_LUI;
          LW: begin
            ctrl_o.dren     = 1'b1;
            ctrl_o.rfin_sel = RFIN_RAM;
          end
          default: ctrl_o.aluop = ALU_ADD;
        endcase
      end
      SW: begin
        ctrl_o.alub_sel = ALUB_EXT;
        ctrl_o.dwen     = 1'b1;
      end
      BEQ:     pc_sel_o = equal_i ? PC_BR : PC_NPC;
      BNE:     pc_sel_o = equal_i ? PC_NPC : PC_BR;
      J:       pc_sel_o = PC_JMP;
      HALT:    ctrl_o.halt = 1'b1;
      default: ctrl_o = '0;
    endcase
  end

endmodule

// File: register_file.sv
module register_file (
  input  logic                    CLK,
  input  logic                    rst_i,
  input  logic                    wen_i,
  input  cpu_types_pkg::regbits_t wsel_i,
  input  cpu_types_pkg::regbits_t rsel1_i,
  input  cpu_types_pkg::regbits_t rsel2_i,
  input  cpu_types_pkg::word_t    wdat_i,
  output cpu_types_pkg::word_t    rdat1_o,
  output cpu_types_pkg::word_t    rdat2_o
);
  import cpu_types_pkg::*;

  word_t regs [32];
  logic  wr_live;

  assign wr_live = wen_i && (wsel_i != '0);

  always_ff @(posedge CLK) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wsel_i] <= wdat_i;
    end
  end

  // Bypass the value being written this cycle
  assign rdat1_o = (wr_live && wsel_i == rsel1_i) ? wdat_i : regs[rsel1_i];
  assign rdat2_o = (wr_live && wsel_i == rsel2_i) ? wdat_i : regs[rsel2_i];

  // r0 keeps its reset value through any write aimed at it
  assert property (@(posedge CLK) disable iff (rst_i)
    (rsel1_i == '0) |-> (rdat1_o == '0));

endmodule

// File: pipe_reg.sv
module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     CLK,
  input  logic     rst_i,
  input  logic     en_i,
  input  logic     flush_i,
  input  payload_t d_i,
  output payload_t q_o
);

  // Zero payload carries all-zero control
  always_ff @(posedge CLK) begin
    if (rst_i || flush_i)
      q_o <= '0;
    else if (en_i)
      q_o <= d_i;
  end

endmodule

// File: forwarding_unit.sv
module forwarding_unit (
  input  cpu_types_pkg::regbits_t ex_rs_i,
  input  cpu_types_pkg::regbits_t ex_rt_i,
  input  cpu_types_pkg::regbits_t id_rs_i,
  input  cpu_types_pkg::regbits_t id_rt_i,
  input  cpu_types_pkg::ctrl_t    mem_ctrl_i,
  input  cpu_types_pkg::ctrl_t    wb_ctrl_i,
  output cpu_types_pkg::fwd_sel_t a_sel_o,
  output cpu_types_pkg::fwd_sel_t b_sel_o,
  output cpu_types_pkg::fwd_sel_t bra_sel_o,
  output cpu_types_pkg::fwd_sel_t brb_sel_o
);
  import cpu_types_pkg::*;

  logic mem_fwd;
  logic wb_fwd;
  logic mem_alu_fwd;

  assign mem_fwd     = mem_ctrl_i.rf_wen && (mem_ctrl_i.wsel != '0);
  assign wb_fwd      = wb_ctrl_i.rf_wen && (wb_ctrl_i.wsel != '0);
  // Load data reaches decode only through the register file
  assign mem_alu_fwd = mem_fwd && !mem_ctrl_i.dren;

  // Newer stage wins
  assign a_sel_o = (mem_fwd && mem_ctrl_i.wsel == ex_rs_i) ? FWD_MEM :
                   (wb_fwd && wb_ctrl_i.wsel == ex_rs_i)   ? FWD_WB  : FWD_NONE;
  assign b_sel_o = (mem_fwd && mem_ctrl_i.wsel == ex_rt_i) ? FWD_MEM :
                   (wb_fwd && wb_ctrl_i.wsel == ex_rt_i)   ? FWD_WB  : FWD_NONE;

  assign bra_sel_o = (mem_alu_fwd && mem_ctrl_i.wsel == id_rs_i) ? FWD_MEM : FWD_NONE;
  assign brb_sel_o = (mem_alu_fwd && mem_ctrl_i.wsel == id_rt_i) ? FWD_MEM : FWD_NONE;

endmodule

// File: hazard_unit.sv
module hazard_unit (
  input  cpu_types_pkg::regbits_t id_rs_i,
  input  cpu_types_pkg::regbits_t id_rt_i,
  input  logic                    id_branch_i,
  input  cpu_types_pkg::ctrl_t    ex_ctrl_i,
  input  cpu_types_pkg::ctrl_t    mem_ctrl_i,
  output logic                    stall_o
);
  import cpu_types_pkg::*;

  logic ex_hit;
  logic mem_hit;
  logic load_use;
  logic branch_wait;

  assign ex_hit  = (ex_ctrl_i.wsel != '0) &&
                   (ex_ctrl_i.wsel == id_rs_i || ex_ctrl_i.wsel == id_rt_i);
  assign mem_hit = (mem_ctrl_i.wsel != '0) &&
                   (mem_ctrl_i.wsel == id_rs_i || mem_ctrl_i.wsel == id_rt_i);

  assign load_use = ex_ctrl_i.dren && ex_hit;

  // Compare in decode needs its operands settled
  assign branch_wait = id_branch_i &&
                       ((ex_ctrl_i.rf_wen && ex_hit) || (mem_ctrl_i.dren && mem_hit));

  assign stall_o = load_use || branch_wait;

endmodule

// File: datapath.sv
module datapath #(
  parameter cpu_types_pkg::word_t PC_INIT = '0
) (
  input  logic                 CLK,
  input  logic                 rst_i,
  output cpu_types_pkg::word_t imem_addr_o,
  input  cpu_types_pkg::word_t imem_load_i,
  output logic                 dmem_ren_o,
  output logic                 dmem_wen_o,
  output cpu_types_pkg::word_t dmem_addr_o,
  output cpu_types_pkg::word_t dmem_store_o,
  input  cpu_types_pkg::word_t dmem_load_i,
  output logic                 halt_o
);
  import cpu_types_pkg::*;

  word_t    pc, npc, pc_next, br_target, jmp_target;
  word_t    rdat1, rdat2, ext32, shamt, jtarget, cmp_a, cmp_b;
  word_t    alu_a, alu_b, fwd_b, alu_out, wdat;
  regbits_t rsel1, rsel2;
  ctrl_t    id_ctrl;
  pc_sel_t  pc_sel;
  fwd_sel_t a_sel, b_sel, bra_sel, brb_sel;
  logic     equal, is_branch, stall, halt_q, pipe_en;
  if_id_t   if_id_d, if_id_q;
  id_ex_t   id_ex_d, id_ex_q;
  ex_mem_t  ex_mem_d, ex_mem_q;
  mem_wb_t  mem_wb_d, mem_wb_q;

  assign pipe_en = !halt_o;

  // Fetch
  assign npc         = pc + 32'd4;
  assign imem_addr_o = pc;
  assign br_target   = if_id_q.npc + {ext32[29:0], 2'b00};
  assign jmp_target  = {if_id_q.npc[31:28], jtarget[27:0]};
  assign pc_next     = (pc_sel == PC_BR) ? br_target : (pc_sel == PC_JMP) ? jmp_target : npc;
  assign if_id_d     = '{instr: imem_load_i, npc: npc};

  always_ff @(posedge CLK) begin
    if (rst_i)
      pc <= PC_INIT;
    else if (pipe_en && !stall)
      pc <= pc_next;
  end

  pipe_reg #(.payload_t(if_id_t)) if_id_reg (
    .CLK, .rst_i, .en_i(pipe_en && !stall),
    .flush_i(pipe_en && !stall && pc_sel != PC_NPC), .d_i(if_id_d), .q_o(if_id_q)
  );

  // Decode with branch compare
  decode_unit decode_unit_i (
    .instr_i(if_id_q.instr), .equal_i(equal), .ctrl_o(id_ctrl),
    .rsel1_o(rsel1), .rsel2_o(rsel2), .ext32_o(ext32), .shamt_o(shamt),
    .is_branch_o(is_branch), .pc_sel_o(pc_sel), .jtarget_o(jtarget)
  );

  register_file register_file_i (
    .CLK, .rst_i, .wen_i(mem_wb_q.ctrl.rf_wen), .wsel_i(mem_wb_q.ctrl.wsel),
    .rsel1_i(rsel1), .rsel2_i(rsel2), .wdat_i(wdat), .rdat1_o(rdat1), .rdat2_o(rdat2)
  );

  assign cmp_a = (bra_sel == FWD_MEM) ? ex_mem_q.aluout : rdat1;
  assign cmp_b = (brb_sel == FWD_MEM) ? ex_mem_q.aluout : rdat2;
  assign equal = (cmp_a == cmp_b);

  assign id_ex_d = '{ctrl: id_ctrl, rs: rsel1, rt: rsel2, rdat1: rdat1,
                     rdat2: rdat2, ext32: ext32, shamt: shamt};

  // Stall leaves a bubble behind decode
  pipe_reg #(.payload_t(id_ex_t)) id_ex_reg (
    .CLK, .rst_i, .en_i(pipe_en), .flush_i(pipe_en && stall),
    .d_i(id_ex_d), .q_o(id_ex_q)
  );

  hazard_unit hazard_unit_i (
    .id_rs_i(rsel1), .id_rt_i(rsel2), .id_branch_i(is_branch),
    .ex_ctrl_i(id_ex_q.ctrl), .mem_ctrl_i(ex_mem_q.ctrl), .stall_o(stall)
  );

  forwarding_unit forwarding_unit_i (
    .ex_rs_i(id_ex_q.rs), .ex_rt_i(id_ex_q.rt), .id_rs_i(rsel1), .id_rt_i(rsel2),
    .mem_ctrl_i(ex_mem_q.ctrl), .wb_ctrl_i(mem_wb_q.ctrl),
    .a_sel_o(a_sel), .b_sel_o(b_sel), .bra_sel_o(bra_sel), .brb_sel_o(brb_sel)
  );

  // Execute
  always_comb begin
    case (a_sel)
      FWD_MEM: alu_a = ex_mem_q.aluout;
      FWD_WB:  alu_a = wdat;
      default: alu_a = id_ex_q.rdat1;
    endcase
    case (b_sel)
      FWD_MEM: fwd_b = ex_mem_q.aluout;
      FWD_WB:  fwd_b = wdat;
      default: fwd_b = id_ex_q.rdat2;
    endcase
    case (id_ex_q.ctrl.alub_sel)
      ALUB_EXT:   alu_b = id_ex_q.ext32;
      ALUB_SHAMT: alu_b = id_ex_q.shamt;
      default:    alu_b = fwd_b;
    endcase
  end

  alu alu_i (.a_i(alu_a), .b_i(alu_b), .op_i(id_ex_q.ctrl.aluop), .out_o(alu_out));

  assign ex_mem_d = '{ctrl: id_ex_q.ctrl, aluout: alu_out, dmemstore: fwd_b};

  pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
    .CLK, .rst_i, .en_i(pipe_en), .flush_i(1'b0), .d_i(ex_mem_d), .q_o(ex_mem_q)
  );

  // Memory
  assign dmem_ren_o   = ex_mem_q.ctrl.dren && !halt_o;
  assign dmem_wen_o   = ex_mem_q.ctrl.dwen && !halt_o;
  assign dmem_addr_o  = ex_mem_q.aluout;
  assign dmem_store_o = ex_mem_q.dmemstore;
  assign mem_wb_d     = '{ctrl: ex_mem_q.ctrl, aluout: ex_mem_q.aluout, dmemload: dmem_load_i};

  pipe_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
    .CLK, .rst_i, .en_i(pipe_en), .flush_i(1'b0), .d_i(mem_wb_d), .q_o(mem_wb_q)
  );

  // Writeback and halt
  assign wdat = (mem_wb_q.ctrl.rfin_sel == RFIN_RAM) ? mem_wb_q.dmemload : mem_wb_q.aluout;

  always_ff @(posedge CLK) begin
    if (rst_i)
      halt_q <= 1'b0;
    else if (mem_wb_q.ctrl.halt)
      halt_q <= 1'b1;
  end

  assign halt_o = halt_q || mem_wb_q.ctrl.halt;

  assert property (@(posedge CLK) disable iff (rst_i)
    !(dmem_ren_o && dmem_wen_o));

  // Second stall cycle only for a load sitting in memory
  assert property (@(posedge CLK) disable iff (rst_i || halt_o)
    stall ##1 stall |-> ex_mem_q.ctrl.dren);

endmodule

// File: tb_datapath.sv
module tb_datapath;
  timeunit 1ns;
  timeprecision 100ps;

  // MIPS major opcodes and function codes
  localparam logic [5:0] OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_ORI   = 6'h0D;
  localparam logic [5:0] OP_LUI   = 6'h0F;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2B;
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] OP_BNE   = 6'h05;
  localparam logic [5:0] FN_SLL   = 6'h00;
  localparam logic [5:0] FN_ADDU  = 6'h21;
  localparam logic [5:0] FN_SUBU  = 6'h23;
  localparam logic [5:0] FN_AND   = 6'h24;
  localparam logic [5:0] FN_OR    = 6'h25;
  localparam logic [5:0] FN_SLT   = 6'h2A;

  logic        CLK;
  logic        rst_i;
  logic [31:0] imem_addr_o;
  logic [31:0] imem_load_i;
  logic        dmem_ren_o;
  logic        dmem_wen_o;
  logic [31:0] dmem_addr_o;
  logic [31:0] dmem_store_o;
  logic [31:0] dmem_load_i;
  logic        halt_o;

  logic [31:0] rom [64];
  logic [31:0] ram [64];
  logic [31:0] gpr [32];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] exp_load [$];
  integer      seed = 69;
  int          prog_len = 0;
  int          store_idx = 0;
  int          load_idx = 0;
  int          cycles = 0;
  int          cycle_limit = 1000;
  logic [15:0] imm;
  logic [4:0]  sh;

  datapath #(.PC_INIT(32'h0)) datapath_i (
    .CLK, .rst_i, .imem_addr_o, .imem_load_i, .dmem_ren_o, .dmem_wen_o,
    .dmem_addr_o, .dmem_store_o, .dmem_load_i, .halt_o
  );

  // Both memories answer in the same cycle
  assign imem_load_i = rom[imem_addr_o[7:2]];
  assign dmem_load_i = ram[dmem_addr_o[7:2]];

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  function automatic logic [31:0] fill_word(int idx);
    return (idx * 32'h0101_0101) ^ 32'h5A00_00C3;
  endfunction

  function automatic logic [31:0] sign_ext(logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic logic [31:0] rtype_word(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
                                             logic [4:0] rd, logic [4:0] shamt);
    return {6'b000000, rs, rt, rd, shamt, fn};
  endfunction

  function automatic logic [31:0] itype_word(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                             logic [15:0] im);
    return {op, rs, rt, im};
  endfunction

  function automatic logic [31:0] jump_word(int idx);
    return {6'b000010, 26'(idx)};
  endfunction

  task automatic put_instr(input logic [31:0] w);
    rom[prog_len] = w;
    prog_len++;
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic expect_load(input logic [31:0] addr);
    exp_load.push_back(addr);
  endtask

  // SW rt, addr(r0) whose data is known
  task automatic store_reg(input logic [4:0] rt, input logic [15:0] addr);
    put_instr(itype_word(OP_SW, 5'd0, rt, addr));
    expect_store({16'h0, addr}, gpr[rt]);
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic build_program();
    for (int i = 0; i < 64; i++) begin
      rom[i] = 32'h0;
      ram[i] <= fill_word(i);
    end
    for (int i = 0; i < 32; i++) begin
      gpr[i] = 32'h0;
    end
    // Back-to-back R-type chain
    imm = 16'($random(seed));
    put_instr(itype_word(OP_ADDIU, 5'd0, 5'd1, imm));
    gpr[1] = sign_ext(imm);
    imm = 16'($random(seed));
    put_instr(itype_word(OP_ADDIU, 5'd0, 5'd2, imm));
    gpr[2] = sign_ext(imm);
    put_instr(rtype_word(FN_ADDU, 5'd1, 5'd2, 5'd3, 5'd0));
    gpr[3] = gpr[1] + gpr[2];
    put_instr(rtype_word(FN_SUBU, 5'd3, 5'd1, 5'd4, 5'd0));
    gpr[4] = gpr[3] - gpr[1];
    put_instr(rtype_word(FN_AND, 5'd4, 5'd3, 5'd5, 5'd0));
    gpr[5] = gpr[4] & gpr[3];
    put_instr(rtype_word(FN_OR, 5'd5, 5'd2, 5'd6, 5'd0));
    gpr[6] = gpr[5] | gpr[2];
    put_instr(rtype_word(FN_SLT, 5'd6, 5'd1, 5'd7, 5'd0));
    gpr[7] = ($signed(gpr[6]) < $signed(gpr[1])) ? 32'd1 : 32'd0;
    store_reg(5'd3, 16'h0080);
    store_reg(5'd4, 16'h0084);
    store_reg(5'd5, 16'h0088);
    store_reg(5'd6, 16'h008C);
    store_reg(5'd7, 16'h0090);
    // Immediate forms
    imm = 16'($random(seed));
    put_instr(itype_word(OP_ORI, 5'd0, 5'd8, imm));
    gpr[8] = {16'h0, imm};
    imm = 16'($random(seed));
    put_instr(itype_word(OP_LUI, 5'd0, 5'd9, imm));
    gpr[9] = {imm, 16'h0};
    sh = 5'($random(seed));
    put_instr(rtype_word(FN_SLL, 5'd0, 5'd8, 5'd10, sh));
    gpr[10] = gpr[8] << sh;
    store_reg(5'd8, 16'h0094);
    store_reg(5'd9, 16'h0098);
    store_reg(5'd10, 16'h009C);
    // Load followed at once by its consumer
    put_instr(itype_word(OP_LW, 5'd0, 5'd11, 16'h0010));
    gpr[11] = fill_word(4);
    expect_load(32'h0000_0010);
    put_instr(rtype_word(FN_ADDU, 5'd11, 5'd2, 5'd12, 5'd0));
    gpr[12] = gpr[11] + gpr[2];
    store_reg(5'd12, 16'h00A0);
    // Taken BEQ on a fresh operand, not-taken BNE, then J
    put_instr(itype_word(OP_ADDIU, 5'd1, 5'd13, 16'h0000));
    gpr[13] = gpr[1];
    put_instr(itype_word(OP_BEQ, 5'd13, 5'd1, 16'd1));
    put_instr(itype_word(OP_SW, 5'd0, 5'd1, 16'h00A4));
    put_instr(itype_word(OP_BNE, 5'd1, 5'd13, 16'd1));
    store_reg(5'd2, 16'h00A8);
    put_instr(jump_word(prog_len + 2));
    put_instr(itype_word(OP_SW, 5'd0, 5'd3, 16'h00AC));
    store_reg(5'd4, 16'h00B0);
    put_instr(32'hFC00_0000);
    // Behind HALT, must never reach the port
    put_instr(itype_word(OP_SW, 5'd0, 5'd5, 16'h00B4));
    cycle_limit = 4 * prog_len + 20;
  endtask

  always @(posedge CLK) begin
    if (!rst_i && dmem_wen_o)
      ram[dmem_addr_o[7:2]] <= dmem_store_o;
  end

  always @(negedge CLK) begin
    if (!rst_i && dmem_wen_o) begin
      if (store_idx >= exp_addr.size()) begin
        $display("Unexpected store to address %h after all expected stores", dmem_addr_o);
        $display("*** FAILED ***");
        $fatal(1, "extra store");
      end else begin
        check_value("store address", dmem_addr_o, exp_addr[store_idx]);
        check_value("store data", dmem_store_o, exp_data[store_idx]);
        store_idx++;
      end
    end
    if (!rst_i && dmem_ren_o) begin
      if (load_idx >= exp_load.size()) begin
        $display("Unexpected load from address %h after all expected loads", dmem_addr_o);
        $display("*** FAILED ***");
        $fatal(1, "extra load");
      end else begin
        check_value("load address", dmem_addr_o, exp_load[load_idx]);
        load_idx++;
      end
    end
  end

  always @(posedge CLK) begin
    if (rst_i) begin
      cycles <= 0;
    end else begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
        $display("Timeout: the core did not halt within %0d cycles", cycle_limit);
        $display("*** FAILED ***");
        $fatal(1, "timeout");
      end
    end
  end

  initial begin
    rst_i = 1'b1;
    build_program();
    repeat (5) @(posedge CLK);
    rst_i <= 1'b0;
    while (halt_o !== 1'b1) @(negedge CLK);
    // A few frozen cycles to catch stray stores
    repeat (4) @(negedge CLK);
    check_value("store count", 32'(store_idx), 32'(exp_addr.size()));
    check_value("load count", 32'(load_idx), 32'(exp_load.size()));
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: vlog.f
cpu_types_pkg.sv
alu.sv
decode_unit.sv
register_file.sv
pipe_reg.sv
forwarding_unit.sv
hazard_unit.sv
datapath.sv
tb_datapath.sv

// File: Makefile
obj_dir/Vtb_datapath: $(wildcard *.sv) vlog.f
	verilator --binary --timing --assert --timescale 1ns/100ps -f vlog.f \
	  --top-module tb_datapath -o Vtb_datapath

run: obj_dir/Vtb_datapath
	obj_dir/Vtb_datapath | tee /dev/stderr | grep -q '^\*\*\* PASSED \*\*\*$$'

clean:
	rm -rf obj_dir

.PHONY: run clean
